/* rtl/ifu_pkg.sv */
package ifu_pkg;

   // a cache line and a fetch are the same size
   localparam int line_bytes_c = 16;
   localparam int line_bits_c = line_bytes_c * 8;
   localparam int line_off_w_c = $clog2(line_bytes_c);

   typedef struct packed {
      logic [31:0] vaddr;
      logic [15:0] cseg;
   } fetch_req_t;

   // linear address plus crossing info for the second read
   typedef struct packed {
      logic [31:0] laddr;
      logic        cross_line;
      logic        cross_page;
      logic [31:0] next_line;
   } addr_info_t;

   typedef struct packed {
      logic [line_bits_c-1:0] data;
      logic                   fault;
   } fetch_rsp_t;

endpackage

/* rtl/tlb_pkg.sv */
package tlb_pkg;

   // apb map, one 8 byte slot per entry
   localparam int entry_stride_c = 8;
   localparam int tag_off_c = 0;
   localparam int data_off_c = 4;

   typedef struct packed {
      logic [19:0] vpn;
      logic [19:0] ppn;
      logic        valid;
      logic        present;
   } pte_t;

   typedef struct packed {
      logic        hit;
      logic [19:0] ppn;
   } tlb_hit_t;

   typedef struct packed {
      logic [19:0] vpn;
      logic [10:0] rsvd;
      logic        valid;
   } tag_word_t;

   typedef struct packed {
      logic [19:0] ppn;
      logic [10:0] rsvd;
      logic        present;
   } data_word_t;

endpackage

/* rtl/ifu_addr_gen.sv */
module ifu_addr_gen
   import ifu_pkg::*;
(
   input  fetch_req_t  fetch_req,
   output addr_info_t  info,
   output logic [19:0] vpn_lo,
   output logic [19:0] vpn_hi
);

   logic [31:0] laddr;
   logic [31-line_off_w_c:0] next_idx;
   logic        off_nz;
   logic        last_line;

   // segment base is cseg << 16
   assign laddr = fetch_req.vaddr + {fetch_req.cseg, 16'h0000};

   assign off_nz = |laddr[line_off_w_c-1:0];

   // last line of the 4k page
   assign last_line = &laddr[11:line_off_w_c];

   assign next_idx = laddr[31:line_off_w_c] + 1'b1;

   assign info.laddr = laddr;
   assign info.cross_line = off_nz;
   assign info.cross_page = off_nz & last_line;
   assign info.next_line = {next_idx, {line_off_w_c{1'b0}}};

   // page of the first byte and the page after it
   assign vpn_lo = laddr[31:12];
   assign vpn_hi = laddr[31:12] + 20'd1;

endmodule

/* rtl/ifu_tlb.sv */
module ifu_tlb
   import tlb_pkg::*;
#(
   parameter int tlb_entries = 8
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   input  logic [19:0] vpn_lo,
   input  logic [19:0] vpn_hi,
   output tlb_hit_t    hit_lo,
   output tlb_hit_t    hit_hi
);

   localparam int idx_w = (tlb_entries > 1) ? $clog2(tlb_entries) : 1;

   pte_t             entry_q [tlb_entries];
   logic [4:0]       apb_idx;
   logic [2:0]       apb_off;
   logic [idx_w-1:0] idx;
   logic             in_range;
   logic             is_tag;
   logic             is_data;
   logic             apb_wr;
   tag_word_t        wr_tag;
   data_word_t       wr_data;
   tag_word_t        rd_tag;
   data_word_t       rd_data;

   function automatic tlb_hit_t lookup(input logic [19:0] vpn);
      tlb_hit_t res;
      res = '0;
      // walk down so the lowest matching entry wins
      for (int i = tlb_entries - 1; i >= 0; i--) begin
         if (entry_q[i].valid && entry_q[i].present && entry_q[i].vpn == vpn) begin
            res.hit = 1'b1;
            res.ppn = entry_q[i].ppn;
         end
      end
      return res;
   endfunction

   assign apb_idx = 5'(paddr / entry_stride_c);
   assign apb_off = 3'(paddr % entry_stride_c);
   assign idx = apb_idx[idx_w-1:0];
   assign in_range = int'(apb_idx) < tlb_entries;
   assign is_tag = int'(apb_off) == tag_off_c;
   assign is_data = int'(apb_off) == data_off_c;
   assign apb_wr = psel & penable & pwrite & in_range;

   assign wr_tag = tag_word_t'(pwdata);
   assign wr_data = data_word_t'(pwdata);

   // no wait states
   assign pready = 1'b1;
   assign pslverr = psel & penable & ~in_range;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < tlb_entries; i++) begin
            entry_q[i] <= '0;
         end
      end else if (apb_wr) begin
         if (is_tag) begin
            entry_q[idx].vpn <= wr_tag.vpn;
            entry_q[idx].valid <= wr_tag.valid;
         end else if (is_data) begin
            entry_q[idx].ppn <= wr_data.ppn;
            entry_q[idx].present <= wr_data.present;
         end
      end
   end

   always_comb begin
      rd_tag = '0;
      rd_data = '0;
      prdata = '0;
      if (in_range) begin
         rd_tag.vpn = entry_q[idx].vpn;
         rd_tag.valid = entry_q[idx].valid;
         rd_data.ppn = entry_q[idx].ppn;
         rd_data.present = entry_q[idx].present;
         if (is_tag) begin
            prdata = rd_tag;
         end else if (is_data) begin
            prdata = rd_data;
         end
      end
   end

   // both pages looked up in parallel
   always_comb begin
      hit_lo = lookup(vpn_lo);
      hit_hi = lookup(vpn_hi);
   end

endmodule

/* rtl/ifu_controller.sv */
module ifu_controller
   import ifu_pkg::*;
   import tlb_pkg::*;
(
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    fetch_valid,
   input  addr_info_t              info,
   input  tlb_hit_t                hit_lo,
   input  tlb_hit_t                hit_hi,
   input  logic                    icache_ready,
   input  logic [line_bits_c-1:0]  icache_data,
   output logic                    icache_en,
   output logic [31:0]             icache_addr,
   output logic                    fetch_stall,
   output logic                    fetch_done,
   output logic                    fault,
   output logic [line_bits_c-1:0]  first_line,
   output logic [line_off_w_c-1:0] offset,
   output logic                    second_phase
);

   typedef enum logic [2:0] {
      st_idle,
      st_fault,
      st_rd1,
      st_rd2,
      st_done
   } state_t;

   state_t                  state_q;
   state_t                  state_d;
   logic                    accept;
   logic                    miss;
   logic [31:0]             addr1_q;
   logic [31:0]             addr2_q;
   logic [line_off_w_c-1:0] offset_q;
   logic                    cross_q;
   logic [line_bits_c-1:0]  line_q;
   logic [19:0]             ppn2;

   assign accept = (state_q == st_idle) && fetch_valid;

   // second page only matters when the fetch leaves the first one
   assign miss = !hit_lo.hit || (info.cross_page && !hit_hi.hit);

   assign ppn2 = info.cross_page ? hit_hi.ppn : hit_lo.ppn;

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (fetch_valid) begin
               state_d = miss ? st_fault : st_rd1;
            end
         end
         st_fault: state_d = st_idle;
         st_rd1: begin
            if (icache_ready) begin
               state_d = cross_q ? st_rd2 : st_done;
            end
         end
         st_rd2: begin
            if (icache_ready) begin
               state_d = st_done;
            end
         end
         st_done: state_d = st_idle;
         default: state_d = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= st_idle;
      end else begin
         state_q <= state_d;
      end
   end

   // physical line addresses fixed at acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         addr1_q <= {hit_lo.ppn, info.laddr[11:line_off_w_c], {line_off_w_c{1'b0}}};
         addr2_q <= {ppn2, info.next_line[11:line_off_w_c], {line_off_w_c{1'b0}}};
         offset_q <= info.laddr[line_off_w_c-1:0];
         cross_q <= info.cross_line;
      end
      if (state_q == st_rd1 && icache_ready) begin
         line_q <= icache_data;
      end
   end

   assign icache_en = (state_q == st_rd1) || (state_q == st_rd2);
   assign icache_addr = (state_q == st_rd2) ? addr2_q : addr1_q;

   assign fetch_stall = state_q != st_idle;
   assign fetch_done = (state_q == st_fault) || (state_q == st_done);
   assign fault = state_q == st_fault;

   assign first_line = line_q;
   assign offset = offset_q;
   assign second_phase = state_q == st_rd2;

endmodule

/* rtl/ifu_line_merge.sv */
module ifu_line_merge
   import ifu_pkg::*;
(
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic [line_bits_c-1:0]  first_line,
   input  logic [line_bits_c-1:0]  icache_data,
   input  logic [line_off_w_c-1:0] offset,
   input  logic                    second_phase,
   input  logic                    fault,
   input  logic                    done,
   output fetch_rsp_t              fetch_rsp
);

   logic [2*line_bits_c-1:0] wide;
   logic [2*line_bits_c-1:0] shifted;
   logic [line_bits_c-1:0]   merged;
   logic [line_bits_c-1:0]   data_q;

   always_comb begin
      // second line sits above the first, then drop offset bytes
      wide = second_phase ? {icache_data, first_line} : {{line_bits_c{1'b0}}, icache_data};
      shifted = wide >> {offset, 3'b000};
      // lowest address goes to the top byte
      for (int j = 0; j < line_bytes_c; j++) begin
         merged[line_bits_c-1-8*j -: 8] = shifted[8*j +: 8];
      end
   end

   // tracks the cache until done, so the last read lands in the done cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_q <= '0;
      end else if (!done) begin
         data_q <= merged;
      end
   end

   assign fetch_rsp.data = fault ? '0 : data_q;
   assign fetch_rsp.fault = fault;

endmodule

/* rtl/ifu_top.sv */
module ifu_top
   import ifu_pkg::*;
   import tlb_pkg::*;
#(
   parameter int tlb_entries = 8
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   fetch_valid,
   input  fetch_req_t             fetch_req,
   output logic                   fetch_stall,
   output logic                   fetch_done,
   output fetch_rsp_t             fetch_rsp,
   output logic                   icache_en,
   output logic [31:0]            icache_addr,
   input  logic                   icache_ready,
   input  logic [line_bits_c-1:0] icache_data,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [7:0]             paddr,
   input  logic [31:0]            pwdata,
   output logic [31:0]            prdata,
   output logic                   pready,
   output logic                   pslverr
);

   addr_info_t              info;
   logic [19:0]             vpn_lo;
   logic [19:0]             vpn_hi;
   tlb_hit_t                hit_lo;
   tlb_hit_t                hit_hi;
   logic                    fault;
   logic [line_bits_c-1:0]  first_line;
   logic [line_off_w_c-1:0] offset;
   logic                    second_phase;

   // decode
   ifu_addr_gen u_addr_gen (
      .fetch_req (fetch_req),
      .info      (info),
      .vpn_lo    (vpn_lo),
      .vpn_hi    (vpn_hi)
   );

   // execute
   ifu_tlb #(
      .tlb_entries (tlb_entries)
   ) u_tlb (
      .clk     (clk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .vpn_lo  (vpn_lo),
      .vpn_hi  (vpn_hi),
      .hit_lo  (hit_lo),
      .hit_hi  (hit_hi)
   );

   ifu_controller u_controller (
      .clk          (clk),
      .arst_n       (arst_n),
      .fetch_valid  (fetch_valid),
      .info         (info),
      .hit_lo       (hit_lo),
      .hit_hi       (hit_hi),
      .icache_ready (icache_ready),
      .icache_data  (icache_data),
      .icache_en    (icache_en),
      .icache_addr  (icache_addr),
      .fetch_stall  (fetch_stall),
      .fetch_done   (fetch_done),
      .fault        (fault),
      .first_line   (first_line),
      .offset       (offset),
      .second_phase (second_phase)
   );

   // result
   ifu_line_merge u_line_merge (
      .clk          (clk),
      .arst_n       (arst_n),
      .first_line   (first_line),
      .icache_data  (icache_data),
      .offset       (offset),
      .second_phase (second_phase),
      .fault        (fault),
      .done         (fetch_done),
      .fetch_rsp    (fetch_rsp)
   );

endmodule

/* test/tb_clock.sv */
module tb_clock #(
   parameter int period = 4
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(period / 2) clk = ~clk;
      end
   end

endmodule

/* test/ifu_checker.sv */
module ifu_checker
   import ifu_pkg::*;
   import tlb_pkg::*;
#(
   parameter int tlb_entries = 8
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   fetch_valid,
   input  fetch_req_t             fetch_req,
   input  logic                   fetch_stall,
   input  logic                   fetch_done,
   input  fetch_rsp_t             fetch_rsp,
   input  logic                   icache_en,
   input  logic [31:0]            icache_addr,
   input  logic                   icache_ready,
   input  pte_t [tlb_entries-1:0] shadow,
   output int                     value_errs,
   output int                     proto_errs
);

   logic        pending;
   fetch_rsp_t  exp_rsp;
   int          reads;
   int          exp_reads;
   logic [31:0] lin;
   logic [31:0] exp_addr1;
   logic [31:0] exp_addr2;
   logic [31:0] exp_addr;

   function automatic logic [7:0] mem_byte(input logic [31:0] a);
      return 8'(a * 7 + 3);
   endfunction

   // physical address through the first usable entry, zero on a miss
   function automatic logic [31:0] phys_addr(input logic [31:0] la,
                                             input pte_t [tlb_entries-1:0] tlb);
      logic [31:0] pa;
      logic        hit;
      pa = '0;
      hit = 1'b0;
      for (int i = 0; i < tlb_entries; i++) begin
         if (!hit && tlb[i].valid && tlb[i].present && tlb[i].vpn == la[31:12]) begin
            hit = 1'b1;
            pa = {tlb[i].ppn, la[11:0]};
         end
      end
      return pa;
   endfunction

   // byte by byte through the page table, lowest address to the top byte
   function automatic fetch_rsp_t ref_fetch(input fetch_req_t req,
                                            input pte_t [tlb_entries-1:0] tlb);
      fetch_rsp_t  r;
      logic [31:0] la;
      logic [31:0] pa;
      logic        hit;
      r = '0;
      for (int k = 0; k < line_bytes_c; k++) begin
         la = req.vaddr + {req.cseg, 16'h0000} + 32'(k);
         hit = 1'b0;
         pa = '0;
         for (int i = 0; i < tlb_entries; i++) begin
            if (!hit && tlb[i].valid && tlb[i].present && tlb[i].vpn == la[31:12]) begin
               hit = 1'b1;
               pa = {tlb[i].ppn, la[11:0]};
            end
         end
         if (!hit) begin
            r.fault = 1'b1;
         end
         r.data[line_bits_c-1-8*k -: 8] = mem_byte(pa);
      end
      if (r.fault) begin
         r.data = '0;
      end
      return r;
   endfunction

   assign lin = fetch_req.vaddr + {fetch_req.cseg, 16'h0000};

   initial begin
      pending = 1'b0;
      exp_rsp = '0;
      reads = 0;
      exp_reads = 0;
      exp_addr1 = '0;
      exp_addr2 = '0;
      exp_addr = '0;
      value_errs = 0;
      proto_errs = 0;
   end

   always @(posedge clk) begin
      if (arst_n) begin
         if (pending && !fetch_stall) begin
            proto_errs++;
            $display("fetch_stall dropped at %0t before fetch_done", $time);
         end
         if (icache_en) begin
            if (!pending) begin
               proto_errs++;
               $display("cache request at %0t with no fetch in flight", $time);
            end else if (exp_rsp.fault) begin
               proto_errs++;
               $display("cache request at %0t after a fault", $time);
            end else begin
               exp_addr = (reads == 0) ? exp_addr1 : exp_addr2;
               if (icache_addr !== exp_addr) begin
                  value_errs++;
                  $display("ERROR t=%0t icache_addr expected %h got %h",
                           $time, exp_addr, icache_addr);
               end
            end
            if (icache_addr[line_off_w_c-1:0] != '0) begin
               proto_errs++;
               $display("cache address %h at %0t is not line-aligned", icache_addr, $time);
            end
            if (icache_ready) begin
               reads++;
            end
         end
         if (fetch_done) begin
            if (!pending) begin
               proto_errs++;
               $display("fetch_done at %0t without a pending fetch", $time);
            end else begin
               if (fetch_rsp.fault !== exp_rsp.fault) begin
                  value_errs++;
                  $display("ERROR t=%0t fetch_rsp.fault expected %0b got %0b",
                           $time, exp_rsp.fault, fetch_rsp.fault);
               end
               if (fetch_rsp.data !== exp_rsp.data) begin
                  value_errs++;
                  $display("ERROR t=%0t fetch_rsp.data expected %h got %h",
                           $time, exp_rsp.data, fetch_rsp.data);
               end
               if (reads != exp_reads) begin
                  proto_errs++;
                  $display("fetch at %0t took %0d cache reads instead of %0d",
                           $time, reads, exp_reads);
               end
               pending = 1'b0;
            end
         end
         // acceptance when the unit is idle
         if (fetch_valid && !fetch_stall) begin
            pending = 1'b1;
            exp_rsp = ref_fetch(fetch_req, shadow);
            reads = 0;
            // line of the first byte and line of the last byte
            exp_addr1 = phys_addr(lin, shadow);
            exp_addr2 = phys_addr(lin + 32'(line_bytes_c - 1), shadow);
            exp_addr1[line_off_w_c-1:0] = '0;
            exp_addr2[line_off_w_c-1:0] = '0;
            if (exp_rsp.fault) begin
               exp_reads = 0;
            end else begin
               exp_reads = (lin[line_off_w_c-1:0] != '0) ? 2 : 1;
            end
         end
      end
   end

endmodule

/* test/ifu_tb.sv */
module ifu_tb
   import ifu_pkg::*;
   import tlb_pkg::*;
();

   localparam int tlb_entries = 8;
   localparam int n_directed = 8;
   localparam int n_random = 40;
   localparam int timeout_c = 60 * (n_directed + n_random) + 200;

   logic                   clk;
   logic                   arst_n;
   logic                   fetch_valid;
   fetch_req_t             fetch_req;
   logic                   fetch_stall;
   logic                   fetch_done;
   fetch_rsp_t             fetch_rsp;
   logic                   icache_en;
   logic [31:0]            icache_addr;
   logic                   icache_ready;
   logic [line_bits_c-1:0] icache_data;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [7:0]             paddr;
   logic [31:0]            pwdata;
   logic [31:0]            prdata;
   logic                   pready;
   logic                   pslverr;

   pte_t [tlb_entries-1:0] shadow;
   int                     value_errs;
   int                     proto_errs;
   int                     apb_errs;
   int                     cycles;
   int                     seed;
   int                     cache_seed;
   int                     wait_cnt;
   logic                   busy;
   logic [31:0]            rd;
   logic                   err;
   logic [19:0]            page;
   logic [11:0]            off;
   logic [15:0]            cseg;

   tb_clock #(.period(4)) u_clock (.clk(clk));

   ifu_top #(
      .tlb_entries (tlb_entries)
   ) uut (
      .clk          (clk),
      .arst_n       (arst_n),
      .fetch_valid  (fetch_valid),
      .fetch_req    (fetch_req),
      .fetch_stall  (fetch_stall),
      .fetch_done   (fetch_done),
      .fetch_rsp    (fetch_rsp),
      .icache_en    (icache_en),
      .icache_addr  (icache_addr),
      .icache_ready (icache_ready),
      .icache_data  (icache_data),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr)
   );

   ifu_checker #(
      .tlb_entries (tlb_entries)
   ) u_checker (
      .clk          (clk),
      .arst_n       (arst_n),
      .fetch_valid  (fetch_valid),
      .fetch_req    (fetch_req),
      .fetch_stall  (fetch_stall),
      .fetch_done   (fetch_done),
      .fetch_rsp    (fetch_rsp),
      .icache_en    (icache_en),
      .icache_addr  (icache_addr),
      .icache_ready (icache_ready),
      .shadow       (shadow),
      .value_errs   (value_errs),
      .proto_errs   (proto_errs)
   );

   function automatic logic [7:0] mem_byte(input logic [31:0] a);
      return 8'(a * 7 + 3);
   endfunction

   function automatic logic [line_bits_c-1:0] line_at(input logic [31:0] base);
      logic [line_bits_c-1:0] l;
      for (int k = 0; k < line_bytes_c; k++) begin
         l[8*k +: 8] = mem_byte(base + 32'(k));
      end
      return l;
   endfunction

   // one apb transfer, setup then access, no wait states
   task automatic apb_xfer(input logic wr, input logic [7:0] a, input logic [31:0] d,
                           output logic [31:0] data, output logic slverr);
      @(negedge clk);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = wr;
      paddr = a;
      pwdata = d;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      data = prdata;
      slverr = pslverr;
      if (pready !== 1'b1) begin
         apb_errs++;
         $display("ERROR t=%0t pready expected 1 got %b", $time, pready);
      end
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic program_entry(input int idx, input logic [19:0] vpn,
                                input logic [19:0] ppn, input logic valid,
                                input logic present);
      logic [31:0] data;
      logic        e1;
      logic        e2;
      apb_xfer(1'b1, 8'(idx * 8), {vpn, 11'h000, valid}, data, e1);
      apb_xfer(1'b1, 8'(idx * 8 + 4), {ppn, 11'h000, present}, data, e2);
      if (e1 || e2) begin
         apb_errs++;
         $display("pslverr on a write to valid entry %0d", idx);
      end
      shadow[idx].vpn = vpn;
      shadow[idx].ppn = ppn;
      shadow[idx].valid = valid;
      shadow[idx].present = present;
   endtask

   task automatic check_entry(input int idx);
      logic [31:0] data;
      logic [31:0] exp;
      logic        e;
      apb_xfer(1'b0, 8'(idx * 8), 32'h0, data, e);
      exp = {shadow[idx].vpn, 11'h000, shadow[idx].valid};
      if (e || data !== exp) begin
         apb_errs++;
         $display("ERROR t=%0t prdata tag %0d expected %h got %h", $time, idx, exp, data);
      end
      apb_xfer(1'b0, 8'(idx * 8 + 4), 32'h0, data, e);
      exp = {shadow[idx].ppn, 11'h000, shadow[idx].present};
      if (e || data !== exp) begin
         apb_errs++;
         $display("ERROR t=%0t prdata data %0d expected %h got %h", $time, idx, exp, data);
      end
   endtask

   // request held until fetch_stall falls again
   task automatic do_fetch(input logic [31:0] vaddr, input logic [15:0] seg);
      @(negedge clk);
      fetch_valid = 1'b1;
      fetch_req.vaddr = vaddr;
      fetch_req.cseg = seg;
      @(negedge clk);
      while (fetch_stall) begin
         @(negedge clk);
      end
      fetch_valid = 1'b0;
   endtask

   // cache model, 0 to 3 wait cycles per read
   always @(negedge clk) begin
      icache_ready = 1'b0;
      if (icache_en) begin
         if (!busy) begin
            busy = 1'b1;
            wait_cnt = $random(cache_seed) & 3;
         end
         if (wait_cnt == 0) begin
            icache_ready = 1'b1;
            icache_data = line_at(icache_addr);
            busy = 1'b0;
         end else begin
            wait_cnt--;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_c) begin
         $display("timeout after %0d cycles, the run did not complete", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      seed = 90352;
      cache_seed = seed + 1;
      cycles = 0;
      apb_errs = 0;
      busy = 1'b0;
      wait_cnt = 0;
      shadow = '0;
      arst_n = 1'b0;
      fetch_valid = 1'b0;
      fetch_req = '0;
      icache_ready = 1'b0;
      icache_data = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;

      program_entry(0, 20'h00010, 20'h00340, 1'b1, 1'b1);
      program_entry(1, 20'h00011, 20'h00777, 1'b1, 1'b1);
      // mapped but not present
      program_entry(2, 20'h00020, 20'h00100, 1'b1, 1'b0);
      program_entry(3, 20'h00030, 20'h00200, 1'b1, 1'b1);
      program_entry(4, 20'h00040, 20'h00500, 1'b0, 1'b1);
      program_entry(5, 20'h00050, 20'h0abcd, 1'b1, 1'b1);
      program_entry(6, 20'h00051, 20'h01234, 1'b1, 1'b1);
      program_entry(7, 20'h00052, 20'h0abce, 1'b1, 1'b1);
      for (int i = 0; i < tlb_entries; i++) begin
         check_entry(i);
      end
      apb_xfer(1'b1, 8'(tlb_entries * 8), 32'h12345001, rd, err);
      if (!err) begin
         apb_errs++;
         $display("write to entry %0d gave no pslverr", tlb_entries);
      end
      apb_xfer(1'b0, 8'hfc, 32'h0, rd, err);
      if (!err) begin
         apb_errs++;
         $display("read from entry 31 gave no pslverr");
      end

      do_fetch(32'h0001_0120, 16'h0000);
      do_fetch(32'h0001_0125, 16'h0000);
      do_fetch(32'h0001_0ff9, 16'h0000);
      do_fetch(32'h0000_0100, 16'h0001);
      do_fetch(32'h0009_9000, 16'h0000);
      do_fetch(32'h0002_0010, 16'h0000);
      do_fetch(32'h0004_0000, 16'h0000);
      // second page 0x31 has no entry
      do_fetch(32'h0003_0ff4, 16'h0000);

      // page 0x53 is unmapped, so some random fetches fault
      repeat (n_random) begin
         page = 20'h00050 + 20'($random(seed) & 3);
         off = 12'($random(seed));
         if (($random(seed) & 3) == 0) begin
            off[11:4] = 8'hff;
         end
         cseg = 16'($random(seed));
         do_fetch({page, off} - {cseg, 16'h0000}, cseg);
      end

      repeat (4) @(negedge clk);
      $display("errors: value %0d, protocol %0d, apb %0d", value_errs, proto_errs, apb_errs);
      if (value_errs + proto_errs + apb_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* ifu.f */
rtl/ifu_pkg.sv
rtl/tlb_pkg.sv
rtl/ifu_addr_gen.sv
rtl/ifu_tlb.sv
rtl/ifu_controller.sv
rtl/ifu_line_merge.sv
rtl/ifu_top.sv
test/tb_clock.sv
test/ifu_checker.sv
test/ifu_tb.sv
